//--- aprRegs.sv
`default_nettype none
`timescale 1ns/1ns

module aprRegs
(
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               clken,
   input  wire [0:ks10AprPkg::cromWidth-1]   crom,
   input  wire ks10AprPkg::aprDataWord       dp,
   input  wire                               nxmIntr,
   input  wire                               cslIntr,
   output logic [22:35]                      aprFlags,
   output ks10AprPkg::aprLevels              aprIntr
);

   import ks10AprPkg::*;

   //////////////////////////////////////////////////
   // Microcode decode
   //////////////////////////////////////////////////

   logic specAprEnable;
   logic specAprFlags;
   logic [4:0] specSel;

   // SPEC select field, only valid with the enable bit
   assign specSel = crom[specSelMsb:specSelLsb];

   assign specAprEnable = crom[specEnBit] && (specSel == selAprEnable);
   assign specAprFlags  = crom[specEnBit] && (specSel == selAprFlags);

   //////////////////////////////////////////////////
   // APR enable register
   //////////////////////////////////////////////////

   logic         trapEn;
   logic         pageEn;
   logic [24:31] flagEn;
   logic         swInt;
   logic [2:0]   aprPri;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         trapEn <= 1'b0;
         pageEn <= 1'b0;
         flagEn <= '0;
         swInt  <= 1'b0;
         aprPri <= '0;
      end
      else if (clken && specAprEnable)
      begin
         // Whole register loads from the enable view
         trapEn <= dp.enable.trapEn;
         pageEn <= dp.enable.pageEn;
         flagEn <= dp.enable.flagEn;
         swInt  <= dp.enable.swInt;
         aprPri <= dp.enable.pri;
      end
   end

   //////////////////////////////////////////////////
   // APR flags 24 to 31
   //////////////////////////////////////////////////

   // 24 software, 25 console request, 26 power fail
   // 27 NXM, 28/29 memory errors, 30 interval timer
   // 31 console interrupt
   logic [24:31] aprFlag;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         aprFlag <= '0;
      end
      else
      begin
         // Microcode write of all eight flags
         if (clken && specAprFlags)
         begin
            aprFlag <= dp.flags.flags;
         end
         // Hardware events are sticky and win over the write
         if (nxmIntr)
         begin
            aprFlag[27] <= 1'b1;
         end
         if (cslIntr)
         begin
            aprFlag[31] <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // Interrupt mask and request level
   //////////////////////////////////////////////////

   logic intReq;

   // Any enabled flag, or the software bit by itself
   assign intReq = (|(aprFlag & flagEn)) || swInt;

   // One-hot on the stored priority
   always_comb
   begin
      aprIntr = '0;
      for (int i = 1; i <= 7; i++)
      begin
         // Priority 0 matches no level, so no request
         aprIntr[i] = intReq && (aprPri == 3'(i));
      end
   end

   //////////////////////////////////////////////////
   // Flags readback, bits 22 to 35
   //////////////////////////////////////////////////

   assign aprFlags[22]    = trapEn;
   assign aprFlags[23]    = pageEn;
   assign aprFlags[24:31] = aprFlag;
   assign aprFlags[32]    = intReq;
   // Bits 33-35 always read as ones
   assign aprFlags[33:35] = 3'b111;

endmodule

`default_nettype wire

//--- aprTop.sv
`default_nettype none
`timescale 1ns/1ns

module aprTop
(
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               clken,
   input  wire [0:ks10AprPkg::cromWidth-1]   crom,
   input  wire ks10AprPkg::aprDataWord       dp,
   input  wire                               cslIntr,
   input  wire ks10AprPkg::aprLevels         ubaIntr,
   // CPU memory side
   input  wire                               memReqValid,
   input  wire [ks10AprPkg::addrWidth-1:0]   memReqAddr,
   output wire                               memReqReady,
   output wire                               memDone,
   output wire                               memNxm,
   // Memory side
   output wire                               memOutValid,
   output wire [ks10AprPkg::addrWidth-1:0]   memOutAddr,
   input  wire                               memOutReady,
   input  wire                               memAck,
   // CPU interrupt side
   output wire                               piReqValid,
   output wire [2:0]                         piReqLevel,
   input  wire                               piReqReady,
   output wire [22:35]                       aprFlags
);

   import ks10AprPkg::*;

   // NXM event into flag 27
   logic nxmIntr;
   // APR request into the PI arbiter
   aprLevels aprIntr;

   aprRegs u_aprRegs (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .crom     (crom),
      .dp       (dp),
      .nxmIntr  (nxmIntr),
      .cslIntr  (cslIntr),
      .aprFlags (aprFlags),
      .aprIntr  (aprIntr)
   );

   nxmMonitor u_nxmMonitor (
      .clk         (clk),
      .rst         (rst),
      .memReqValid (memReqValid),
      .memReqAddr  (memReqAddr),
      .memOutReady (memOutReady),
      .memAck      (memAck),
      .memReqReady (memReqReady),
      .memOutValid (memOutValid),
      .memOutAddr  (memOutAddr),
      .memDone     (memDone),
      .memNxm      (memNxm),
      .nxmIntr     (nxmIntr)
   );

   piArbiter u_piArbiter (
      .clk        (clk),
      .rst        (rst),
      .clken      (clken),
      .crom       (crom),
      .dp         (dp),
      .aprIntr    (aprIntr),
      .ubaIntr    (ubaIntr),
      .piReqReady (piReqReady),
      .piReqValid (piReqValid),
      .piReqLevel (piReqLevel)
   );

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
ks10AprPkg.sv
aprRegs.sv
nxmMonitor.sv
piArbiter.sv
aprTop.sv
tbAprTop.sv

//--- ks10AprPkg.sv
`default_nettype none

package ks10AprPkg;

   //////////////////////////////////////////////////
   // Word widths
   //////////////////////////////////////////////////

   localparam int dataWidth = 36;
   localparam int cromWidth = 108;
   localparam int addrWidth = 20;

   //////////////////////////////////////////////////
   // Control-ROM special-function field
   //////////////////////////////////////////////////

   // Bit 0 is the leftmost bit of the control word
   localparam int specEnBit  = 42;
   localparam int specSelMsb = 45;
   localparam int specSelLsb = 49;

   // Select codes in the 5-bit SPEC field
   localparam logic [4:0] selAprEnable = 5'h15;
   localparam logic [4:0] selAprFlags  = 5'h16;
   localparam logic [4:0] selPiWrite   = 5'h17;
   localparam logic [4:0] selPiDismiss = 5'h18;

   //////////////////////////////////////////////////
   // Memory timeout
   //////////////////////////////////////////////////

   // Cycles allowed between output transfer and ack
   localparam int nxmTimeout = 16;

   // NXM monitor state codes
   localparam logic [1:0] nxmIdle  = 2'd0;
   localparam logic [1:0] nxmIssue = 2'd1;
   localparam logic [1:0] nxmWait  = 2'd2;

   //////////////////////////////////////////////////
   // Interrupt levels and data-path word
   //////////////////////////////////////////////////

   // One-hot level vector, level 1 is the highest
   typedef logic [1:7] aprLevels;

   // First member lands on DEC bit 0, the MSB
   typedef struct packed {
      logic [0:21] pad;
      logic        trapEn;
      logic        pageEn;
      logic [24:31] flagEn;
      logic        swInt;
      logic [2:0]  pri;
   } aprEnableView;

   typedef struct packed {
      logic [0:23]  padHi;
      logic [24:31] flags;
      logic [32:35] padLo;
   } aprFlagsView;

   typedef struct packed {
      logic [0:27] pad;
      logic        piOn;
      aprLevels    levelEn;
   } aprPiView;

   // Same 36 bits, decoded per SPEC select
   typedef union packed {
      aprEnableView enable;
      aprFlagsView  flags;
      aprPiView     pi;
   } aprDataWord;

endpackage

`default_nettype wire

//--- nxmMonitor.sv
`default_nettype none
`timescale 1ns/1ns

module nxmMonitor
(
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               memReqValid,
   input  wire [ks10AprPkg::addrWidth-1:0]   memReqAddr,
   input  wire                               memOutReady,
   input  wire                               memAck,
   output logic                              memReqReady,
   output logic                              memOutValid,
   output logic [ks10AprPkg::addrWidth-1:0]  memOutAddr,
   output logic                              memDone,
   output logic                              memNxm,
   output logic                              nxmIntr
);

   import ks10AprPkg::*;

   logic [1:0] state;
   logic [$clog2(nxmTimeout)-1:0] waitCount;
   logic timeoutHit;

   // Accept a new request only when idle
   assign memReqReady = (state == nxmIdle);
   assign memOutValid = (state == nxmIssue);

   // Address payload captured on acceptance
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         memOutAddr <= '0;
      end
      else if (memReqValid && memReqReady)
      begin
         memOutAddr <= memReqAddr;
      end
   end

   //////////////////////////////////////////////////
   // Request FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state      <= nxmIdle;
         waitCount  <= '0;
         memDone    <= 1'b0;
         timeoutHit <= 1'b0;
      end
      else
      begin
         // Done and NXM are single-cycle pulses
         memDone    <= 1'b0;
         timeoutHit <= 1'b0;
         case (state)
            nxmIdle:
            begin
               if (memReqValid)
               begin
                  state <= nxmIssue;
               end
            end
            nxmIssue:
            begin
               // Stalled output does not count toward the timeout
               if (memOutReady)
               begin
                  waitCount <= '0;
                  state     <= nxmWait;
               end
            end
            nxmWait:
            begin
               if (memAck)
               begin
                  memDone <= 1'b1;
                  state   <= nxmIdle;
               end
               else if (waitCount == ($clog2(nxmTimeout))'(nxmTimeout - 1))
               begin
                  // Nobody answered, so the memory does not exist
                  memDone    <= 1'b1;
                  timeoutHit <= 1'b1;
                  state      <= nxmIdle;
               end
               else
               begin
                  waitCount <= waitCount + 1'b1;
               end
            end
            default:
            begin
               state <= nxmIdle;
            end
         endcase
      end
   end

   // Same timeout pulse goes to the CPU and the APR
   assign memNxm  = timeoutHit;
   assign nxmIntr = timeoutHit;

endmodule

`default_nettype wire

//--- piArbiter.sv
`default_nettype none
`timescale 1ns/1ns

module piArbiter
(
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               clken,
   input  wire [0:ks10AprPkg::cromWidth-1]   crom,
   input  wire ks10AprPkg::aprDataWord       dp,
   input  wire ks10AprPkg::aprLevels         aprIntr,
   input  wire ks10AprPkg::aprLevels         ubaIntr,
   input  wire                               piReqReady,
   output logic                              piReqValid,
   output logic [2:0]                        piReqLevel
);

   import ks10AprPkg::*;

   //////////////////////////////////////////////////
   // Microcode decode
   //////////////////////////////////////////////////

   logic [4:0] specSel;
   logic specPiWrite;
   logic specPiDismiss;

   assign specSel       = crom[specSelMsb:specSelLsb];
   assign specPiWrite   = crom[specEnBit] && (specSel == selPiWrite);
   assign specPiDismiss = crom[specEnBit] && (specSel == selPiDismiss);

   //////////////////////////////////////////////////
   // Level merge and priority select
   //////////////////////////////////////////////////

   logic     piOn;
   aprLevels levelEn;
   aprLevels inProg;
   aprLevels piReq;
   aprLevels dismissMask;
   logic     found;
   logic [2:0] pick;

   // APR and bus-adapter requests share the seven levels
   assign piReq = piOn ? ((aprIntr | ubaIntr) & levelEn) : '0;

   always_comb
   begin : selectLevel
      logic blocked;
      blocked = 1'b0;
      found   = 1'b0;
      pick    = '0;
      // Scan from level 1 down, stop at the first busy level
      for (int i = 1; i <= 7; i++)
      begin
         blocked = blocked | inProg[i];
         if (!found && !blocked && piReq[i])
         begin
            found = 1'b1;
            pick  = 3'(i);
         end
      end
   end

   // Highest in-progress level, cleared by dismiss
   always_comb
   begin : findHighest
      logic seen;
      seen = 1'b0;
      for (int i = 1; i <= 7; i++)
      begin
         dismissMask[i] = inProg[i] && !seen;
         seen           = seen | inProg[i];
      end
   end

   //////////////////////////////////////////////////
   // PI register, handshake, in-progress
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         piOn       <= 1'b0;
         levelEn    <= '0;
         inProg     <= '0;
         piReqValid <= 1'b0;
         piReqLevel <= '0;
      end
      else
      begin
         if (clken && specPiWrite)
         begin
            piOn    <= dp.pi.piOn;
            levelEn <= dp.pi.levelEn;
         end
         if (clken && specPiDismiss)
         begin
            inProg <= inProg & ~dismissMask;
         end
         // Offer is frozen until the CPU takes it
         if (piReqValid)
         begin
            if (piReqReady)
            begin
               piReqValid         <= 1'b0;
               inProg[piReqLevel] <= 1'b1;
            end
         end
         else if (found)
         begin
            piReqValid <= 1'b1;
            piReqLevel <= pick;
         end
      end
   end

endmodule

`default_nettype wire

//--- tbAprChecks.svh
`ifndef tbAprChecksSvh
`define tbAprChecksSvh

//////////////////////////////////////////////////
// Result counters
//////////////////////////////////////////////////

int errorCount = 0;
int checkCount = 0;
int testCount  = 0;
// Error count when the current test started
int errStart   = 0;

// One line per finished test
task automatic reportTest(input string name);
   testCount++;
   $display("%-14s done, %0d error(s)", name, errorCount - errStart);
endtask

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

// One-hot APR request into the arbiter
task automatic checkLevels(input aprLevels got, input aprLevels exp);
   checkCount++;
   if (got !== exp)
   begin
      $display("FAIL aprIntr got %h expected %h", got, exp);
      errorCount++;
   end
endtask

// Flags readback, bits 22 to 35
task automatic checkFlags(input logic [22:35] got, input logic [22:35] exp);
   checkCount++;
   if (got !== exp)
   begin
      $display("FAIL aprFlags got %h expected %h", got, exp);
      errorCount++;
   end
endtask

// Offered PI level
task automatic checkLevel(input logic [2:0] got, input logic [2:0] exp);
   checkCount++;
   if (got !== exp)
   begin
      $display("FAIL piReqLevel got %h expected %h", got, exp);
      errorCount++;
   end
endtask

task automatic checkAddr(input logic [addrWidth-1:0] got, input logic [addrWidth-1:0] exp);
   checkCount++;
   if (got !== exp)
   begin
      $display("FAIL memOutAddr got %h expected %h", got, exp);
      errorCount++;
   end
endtask

// Single-bit handshake and status outputs
task automatic checkBit(input string name, input logic got, input logic exp);
   checkCount++;
   if (got !== exp)
   begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errorCount++;
   end
endtask

//////////////////////////////////////////////////
// Timed waits, sampled on the falling edge
//////////////////////////////////////////////////

task automatic waitPiValid(input int limit);
   int n;
   n = 0;
   while (piReqValid !== 1'b1 && n < limit)
   begin
      @(negedge clk);
      n++;
   end
   if (piReqValid !== 1'b1)
   begin
      $display("Timed out waiting for an interrupt offer on piReqValid");
      errorCount++;
   end
endtask

task automatic waitMemOutValid(input int limit);
   int n;
   n = 0;
   while (memOutValid !== 1'b1 && n < limit)
   begin
      @(negedge clk);
      n++;
   end
   if (memOutValid !== 1'b1)
   begin
      $display("Timed out waiting for the memory request on memOutValid");
      errorCount++;
   end
endtask

`endif

//--- tbAprTop.sv
`default_nettype none
`timescale 1ns/1ns

module tbAprTop;

   import ks10AprPkg::*;

   logic                  clk;
   logic                  rst;
   logic                  clken;
   logic [0:cromWidth-1]  crom;
   aprDataWord            dp;
   logic                  cslIntr;
   aprLevels              ubaIntr;
   logic                  memReqValid;
   logic [addrWidth-1:0]  memReqAddr;
   logic                  memOutReady;
   logic                  memAck;
   logic                  piReqReady;
   wire                   memReqReady;
   wire                   memDone;
   wire                   memNxm;
   wire                   memOutValid;
   wire [addrWidth-1:0]   memOutAddr;
   wire                   piReqValid;
   wire [2:0]             piReqLevel;
   wire [22:35]           aprFlags;
   integer                seed = 64213;

   aprTop u_dut (
      .clk         (clk),
      .rst         (rst),
      .clken       (clken),
      .crom        (crom),
      .dp          (dp),
      .cslIntr     (cslIntr),
      .ubaIntr     (ubaIntr),
      .memReqValid (memReqValid),
      .memReqAddr  (memReqAddr),
      .memReqReady (memReqReady),
      .memDone     (memDone),
      .memNxm      (memNxm),
      .memOutValid (memOutValid),
      .memOutAddr  (memOutAddr),
      .memOutReady (memOutReady),
      .memAck      (memAck),
      .piReqValid  (piReqValid),
      .piReqLevel  (piReqLevel),
      .piReqReady  (piReqReady),
      .aprFlags    (aprFlags)
   );

   `include "tbAprChecks.svh"

   // 8 ns period
   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Stimulus helpers entered and left on a negedge
   //////////////////////////////////////////////////

   // Control word with only the SPEC field set
   function automatic logic [0:cromWidth-1] specWord(input logic [4:0] sel);
      logic [0:cromWidth-1] w;
      w = '0;
      w[specEnBit] = 1'b1;
      w[specSelMsb:specSelLsb] = sel;
      return w;
   endfunction

   function automatic aprDataWord enableWord(input logic [24:31] en, input logic sw,
                                             input logic [2:0] pri);
      aprDataWord w;
      w = '0;
      w.enable.flagEn = en;
      w.enable.swInt  = sw;
      w.enable.pri    = pri;
      return w;
   endfunction

   function automatic aprDataWord flagsWord(input logic [24:31] f);
      aprDataWord w;
      w = '0;
      w.flags.flags = f;
      return w;
   endfunction

   function automatic aprDataWord piWord(input logic on, input aprLevels en);
      aprDataWord w;
      w = '0;
      w.pi.piOn    = on;
      w.pi.levelEn = en;
      return w;
   endfunction

   // Expected readback of trap, paging, flags, request and three ones
   function automatic logic [22:35] readback(input logic trap, input logic page,
                                             input logic [24:31] f, input logic req);
      return {trap, page, f, req, 3'b111};
   endfunction

   // One microcode cycle with a SPEC write
   task automatic specWrite(input logic [4:0] sel, input aprDataWord word);
      crom = specWord(sel);
      dp   = word;
      @(negedge clk);
      crom = '0;
      dp   = '0;
   endtask

   task automatic clearApr();
      specWrite(selAprEnable, '0);
      specWrite(selAprFlags, '0);
   endtask

   // CPU takes the current offer
   task automatic acceptOffer();
      piReqReady = 1'b1;
      @(negedge clk);
      piReqReady = 1'b0;
   endtask

   task automatic checkNoOffer(input int cycles);
      repeat (cycles)
      begin
         @(negedge clk);
         checkBit("piReqValid", piReqValid, 1'b0);
      end
   endtask

   // Accept and stall the output, then return right after the output transfer
   task automatic issueRequest(input logic [addrWidth-1:0] addr, input int stall);
      checkBit("memReqReady", memReqReady, 1'b1);
      memReqValid = 1'b1;
      memReqAddr  = addr;
      memOutReady = 1'b0;
      @(negedge clk);
      memReqValid = 1'b0;
      memReqAddr  = '0;
      waitMemOutValid(8);
      repeat (stall)
      begin
         checkAddr(memOutAddr, addr);
         @(negedge clk);
         checkBit("memOutValid", memOutValid, 1'b1);
      end
      checkAddr(memOutAddr, addr);
      memOutReady = 1'b1;
      @(negedge clk);
      memOutReady = 1'b0;
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////

   task automatic regWrites();
      aprDataWord ew;
      aprDataWord fw;
      logic [63:0] r;
      logic req;
      errStart = errorCount;
      // Reset state first
      checkBit("memReqReady", memReqReady, 1'b1);
      checkBit("piReqValid", piReqValid, 1'b0);
      checkBit("memDone", memDone, 1'b0);
      checkFlags(aprFlags, readback(1'b0, 1'b0, 8'h00, 1'b0));
      repeat (8)
      begin
         r  = {$random(seed), $random(seed)};
         ew = r[35:0];
         r  = {$random(seed), $random(seed)};
         fw = r[35:0];
         specWrite(selAprEnable, ew);
         specWrite(selAprFlags, fw);
         // Request when the software bit is on or a set flag has its enable
         req = ew.enable.swInt;
         for (int i = 24; i <= 31; i++)
         begin
            if (fw.flags.flags[i] && ew.enable.flagEn[i])
            begin
               req = 1'b1;
            end
         end
         checkFlags(aprFlags, readback(ew.enable.trapEn, ew.enable.pageEn,
                                       fw.flags.flags, req));
      end
      reportTest("regWrites");
   endtask

   task automatic levelMapping();
      aprLevels expLevels;
      errStart = errorCount;
      clearApr();
      specWrite(selPiWrite, piWord(1'b1, 7'h7f));
      for (int p = 0; p <= 7; p++)
      begin
         for (int sw = 0; sw <= 1; sw++)
         begin
            expLevels = '0;
            if (p != 0)
            begin
               expLevels[p] = 1'b1;
            end
            if (sw == 1)
            begin
               specWrite(selAprEnable, enableWord(8'h00, 1'b1, 3'(p)));
            end
            else
            begin
               // Flag 24 with its enable
               specWrite(selAprEnable, enableWord(8'h80, 1'b0, 3'(p)));
               specWrite(selAprFlags, flagsWord(8'h80));
            end
            checkLevels(u_dut.aprIntr, expLevels);
            if (p == 0)
            begin
               checkNoOffer(4);
            end
            else
            begin
               waitPiValid(8);
               checkLevel(piReqLevel, 3'(p));
               acceptOffer();
            end
            clearApr();
            if (p != 0)
            begin
               specWrite(selPiDismiss, '0);
            end
         end
      end
      // Flag set but not enabled
      specWrite(selAprEnable, enableWord(8'h00, 1'b0, 3'd3));
      specWrite(selAprFlags, flagsWord(8'h80));
      checkLevels(u_dut.aprIntr, '0);
      checkNoOffer(4);
      clearApr();
      reportTest("levelMapping");
   endtask

   task automatic consoleIntr();
      errStart = errorCount;
      clearApr();
      // Console pulse against a flags write of zero
      crom    = specWord(selAprFlags);
      dp      = flagsWord(8'h00);
      cslIntr = 1'b1;
      @(negedge clk);
      crom    = '0;
      dp      = '0;
      cslIntr = 1'b0;
      checkFlags(aprFlags, readback(1'b0, 1'b0, 8'h01, 1'b0));
      specWrite(selAprFlags, flagsWord(8'h00));
      checkFlags(aprFlags, readback(1'b0, 1'b0, 8'h00, 1'b0));
      reportTest("consoleIntr");
   endtask

   task automatic memTimeout();
      errStart = errorCount;
      clearApr();
      // Acknowledged request after back-pressure
      issueRequest(20'h1234a, 3);
      memAck = 1'b1;
      @(negedge clk);
      memAck = 1'b0;
      checkBit("memDone", memDone, 1'b1);
      checkBit("memNxm", memNxm, 1'b0);
      @(negedge clk);
      checkBit("memDone", memDone, 1'b0);
      checkFlags(aprFlags, readback(1'b0, 1'b0, 8'h00, 1'b0));
      // Without acknowledge the request ends exactly at the timeout
      issueRequest(20'hfff00, 2);
      for (int n = 1; n <= nxmTimeout; n++)
      begin
         @(negedge clk);
         checkBit("memDone", memDone, n == nxmTimeout);
         checkBit("memNxm", memNxm, n == nxmTimeout);
      end
      // Flag 27 one cycle later
      @(negedge clk);
      checkFlags(aprFlags, readback(1'b0, 1'b0, 8'h10, 1'b0));
      clearApr();
      reportTest("memTimeout");
   endtask

   task automatic piArbitration();
      errStart = errorCount;
      clearApr();
      specWrite(selPiWrite, piWord(1'b1, 7'h7f));
      ubaIntr[2] = 1'b1;
      ubaIntr[5] = 1'b1;
      waitPiValid(8);
      checkLevel(piReqLevel, 3'd2);
      // Higher request during the stall must not change the offer
      ubaIntr[1] = 1'b1;
      repeat (3)
      begin
         @(negedge clk);
         checkBit("piReqValid", piReqValid, 1'b1);
         checkLevel(piReqLevel, 3'd2);
      end
      ubaIntr[1] = 1'b0;
      ubaIntr[2] = 1'b0;
      acceptOffer();
      // Level 5 sits below level 2 in progress
      checkNoOffer(4);
      specWrite(selPiDismiss, '0);
      waitPiValid(8);
      checkLevel(piReqLevel, 3'd5);
      acceptOffer();
      ubaIntr = '0;
      specWrite(selPiDismiss, '0);
      // Level 4 disabled
      specWrite(selPiWrite, piWord(1'b1, 7'b1110111));
      ubaIntr[4] = 1'b1;
      checkNoOffer(4);
      // PI system off
      specWrite(selPiWrite, piWord(1'b0, 7'h7f));
      ubaIntr = 7'h7f;
      checkNoOffer(4);
      ubaIntr = '0;
      reportTest("piArbitration");
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      rst         = 1'b1;
      clken       = 1'b0;
      crom        = '0;
      dp          = '0;
      cslIntr     = 1'b0;
      ubaIntr     = '0;
      memReqValid = 1'b0;
      memReqAddr  = '0;
      memOutReady = 1'b0;
      memAck      = 1'b0;
      piReqReady  = 1'b0;
      // Two cycles of reset
      repeat (2) @(negedge clk);
      rst   = 1'b0;
      clken = 1'b1;
      regWrites();
      levelMapping();
      consoleIntr();
      memTimeout();
      piArbitration();
      $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
      if (errorCount == 0)
      begin
         $display("TEST PASSED");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Overall limit on simulated time
   initial
   begin
      #200000;
      $display("Simulation did not finish within the time limit");
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire
